// File: design/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int WB_ADDR_W = 10;  // word address, 1024 words
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_SEL_W-1:0]  sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat_r;
    } wb_resp_t;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, viewed through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

module regfile
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire [4:0]       rs1_addr,
    input  wire [4:0]       rs2_addr,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    input  wire             we,
    input  wire [4:0]       rd_addr,
    input  wire [XLEN-1:0]  rd_data,
    output logic [XLEN-1:0] exit_value
);

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign exit_value = regs[10];  // a0

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu
    import rv_isa_pkg::*;
(
    input  var alu_op_e     op,
    input  wire [XLEN-1:0]  a,
    input  wire [XLEN-1:0]  b,
    output logic [XLEN-1:0] y,
    output logic            equal
);

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_PASS_B: y = b;       // lui
            default:    y = '0;
        endcase
    end

    // beq/bne compare rs1 against rs2 directly
    assign equal = (a == b);

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`default_nettype none

module fetch_unit
    import wb_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             run,
    output wb_req_t         wb_req,
    input  var wb_resp_t    wb_resp,
    output inst_u           inst,
    output logic [XLEN-1:0] pc,
    output logic            inst_valid,
    input  wire             inst_taken,
    input  wire [XLEN-1:0]  next_pc
);

    typedef enum logic {
        S_FETCH,
        S_HOLD
    } state_e;

    state_e state;
    logic   pending;  // bus cycle already open, keep it until ack

    assign wb_req.cyc   = (state == S_FETCH) && (run || pending);
    assign wb_req.stb   = wb_req.cyc;
    assign wb_req.we    = 1'b0;
    assign wb_req.sel   = '1;
    assign wb_req.adr   = pc[WB_ADDR_W+1:2];
    assign wb_req.dat_w = '0;

    assign inst_valid = (state == S_HOLD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_FETCH;
            pending <= 1'b0;
            pc      <= RESET_PC;
        end else begin
            pending <= wb_req.cyc && !wb_resp.ack;
            case (state)
                S_FETCH: if (wb_resp.ack) state <= S_HOLD;
                S_HOLD: begin
                    if (inst_taken) begin
                        state <= S_FETCH;
                        pc    <= next_pc;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && wb_resp.ack) begin
            inst <= wb_resp.dat_r;
        end
    end

endmodule

`default_nettype wire

// File: design/core_ctrl.sv
`default_nettype none

module core_ctrl
    import wb_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  var inst_u       inst,
    input  wire [XLEN-1:0]  pc,
    input  wire             inst_valid,
    output logic            inst_taken,
    output logic [XLEN-1:0] next_pc,
    output wb_req_t         wb_req,
    input  var wb_resp_t    wb_resp,
    output logic            halted,
    output logic            trap,
    output logic [XLEN-1:0] trap_pc,
    output logic [XLEN-1:0] exit_value
);

    typedef enum logic [1:0] {
        S_WAIT,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e          state;
    alu_op_e         alu_op;
    logic [XLEN-1:0] rs1_data, rs2_data, alu_b, alu_y;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0] pc_plus4, wr_data, rf_wdata;
    logic            equal, legal, wr_en, is_mem, is_store, is_ebreak, rf_we;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                    inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                    inst.j.imm10_1, 1'b0};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        legal     = 1'b0;
        wr_en     = 1'b0;
        is_mem    = 1'b0;
        is_store  = 1'b0;
        is_ebreak = 1'b0;
        alu_op    = ALU_ADD;
        alu_b     = rs2_data;
        wr_data   = alu_y;
        next_pc   = pc_plus4;
        case (inst.r.opcode)
            OP_LUI: begin
                legal  = 1'b1;
                wr_en  = 1'b1;
                alu_op = ALU_PASS_B;
                alu_b  = imm_u;
            end
            OP_IMM: begin
                legal = (inst.i.funct3 == F3_ADD_SUB);  // addi only
                wr_en = 1'b1;
                alu_b = imm_i;
            end
            OP_REG: begin
                wr_en = 1'b1;
                legal = 1'b1;
                if (inst.r.funct7 == F7_SUB && inst.r.funct3 == F3_ADD_SUB) alu_op = ALU_SUB;
                else if (inst.r.funct7 != F7_BASE) legal = 1'b0;
                else if (inst.r.funct3 == F3_ADD_SUB) alu_op = ALU_ADD;
                else if (inst.r.funct3 == F3_AND) alu_op = ALU_AND;
                else if (inst.r.funct3 == F3_OR) alu_op = ALU_OR;
                else if (inst.r.funct3 == F3_XOR) alu_op = ALU_XOR;
                else legal = 1'b0;
            end
            OP_LOAD: begin
                legal  = (inst.i.funct3 == F3_LW);
                wr_en  = 1'b1;
                is_mem = 1'b1;
                alu_b  = imm_i;
            end
            OP_STORE: begin
                legal    = (inst.s.funct3 == F3_SW);
                is_mem   = 1'b1;
                is_store = 1'b1;
                alu_b    = imm_s;
            end
            OP_BRANCH: begin
                legal = (inst.b.funct3 == F3_BEQ) || (inst.b.funct3 == F3_BNE);
                if ((inst.b.funct3 == F3_BEQ) == equal) next_pc = pc + imm_b;
            end
            OP_JAL: begin
                legal   = 1'b1;
                wr_en   = 1'b1;
                wr_data = pc_plus4;  // link
                next_pc = pc + imm_j;
            end
            OP_SYSTEM: begin
                legal     = (inst == EBREAK_WORD);
                is_ebreak = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign inst_taken = (state == S_EXEC && legal && !is_ebreak && !is_mem)
                     || (state == S_MEM && wb_resp.ack);
    assign rf_we      = inst_taken && wr_en;
    assign rf_wdata   = is_mem ? wb_resp.dat_r : wr_data;

    assign wb_req.cyc   = (state == S_MEM);
    assign wb_req.stb   = (state == S_MEM);
    assign wb_req.we    = is_store;
    assign wb_req.sel   = '1;
    assign wb_req.adr   = alu_y[WB_ADDR_W+1:2];
    assign wb_req.dat_w = rs2_data;

    assign halted = (state == S_HALT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_WAIT;
            trap  <= 1'b0;
        end else begin
            case (state)
                S_WAIT: if (inst_valid) state <= S_EXEC;
                S_EXEC: begin
                    if (!legal || is_ebreak) begin
                        state <= S_HALT;
                        trap  <= !legal;
                    end else if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        state <= S_WAIT;
                    end
                end
                S_MEM: if (wb_resp.ack) state <= S_WAIT;
                default: state <= S_HALT;  // stays halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC && !legal) trap_pc <= pc;
    end

    regfile u_regfile (
        .clk       (clk),
        .rs1_addr  (inst.r.rs1),
        .rs2_addr  (inst.r.rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .we        (rf_we),
        .rd_addr   (inst.r.rd),
        .rd_data   (rf_wdata),
        .exit_value(exit_value)
    );

    alu u_alu (
        .op   (alu_op),
        .a    (rs1_data),
        .b    (alu_b),
        .y    (alu_y),
        .equal(equal)
    );

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`default_nettype none

module wb_arbiter
    import wb_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  var wb_req_t  m_host_req,
    input  var wb_req_t  m_data_req,
    input  var wb_req_t  m_inst_req,
    output wb_resp_t     m_host_resp,
    output wb_resp_t     m_data_resp,
    output wb_resp_t     m_inst_resp,
    output wb_req_t      s_req,
    input  var wb_resp_t s_resp
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_HOST,
        OWN_DATA,
        OWN_INST
    } owner_e;

    owner_e owner;

    always_comb begin
        case (owner)
            OWN_HOST: s_req = m_host_req;
            OWN_DATA: s_req = m_data_req;
            OWN_INST: s_req = m_inst_req;
            default:  s_req = '0;
        endcase
    end

    // grant only from idle, drop it once the owner lets go of cyc
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (owner == OWN_NONE) begin
            if (m_host_req.cyc) owner <= OWN_HOST;
            else if (m_data_req.cyc) owner <= OWN_DATA;
            else if (m_inst_req.cyc) owner <= OWN_INST;
        end else if (!s_req.cyc) begin
            owner <= OWN_NONE;
        end
    end

    // losers see no ack and just keep stb up
    assign m_host_resp = (owner == OWN_HOST) ? s_resp : wb_resp_t'('0);
    assign m_data_resp = (owner == OWN_DATA) ? s_resp : wb_resp_t'('0);
    assign m_inst_resp = (owner == OWN_INST) ? s_resp : wb_resp_t'('0);

endmodule

`default_nettype wire

// File: design/wb_ram.sv
`default_nettype none

module wb_ram
    import wb_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  var wb_req_t req,
    output wb_resp_t    resp
);

    logic [WB_DATA_W-1:0] mem [0:(1<<WB_ADDR_W)-1];
    logic                 ack_q;
    logic [WB_DATA_W-1:0] rdata_q;
    logic                 access;

    assign access = req.cyc && req.stb && !ack_q;  // new request, no ack outstanding

    always_ff @(posedge clk) begin
        if (rst) ack_q <= 1'b0;
        else ack_q <= access;
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                for (int i = 0; i < WB_SEL_W; i++) begin
                    if (req.sel[i]) mem[req.adr][i*8 +: 8] <= req.dat_w[i*8 +: 8];
                end
            end
            rdata_q <= mem[req.adr];
        end
    end

    assign resp.ack   = ack_q;
    assign resp.dat_r = rdata_q;

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none

module cpu_top
    import wb_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire             run,
    input  var wb_req_t     host_req,
    output wb_resp_t        host_resp,
    output logic            halted,
    output logic            trap,
    output logic [XLEN-1:0] trap_pc,
    output logic [XLEN-1:0] exit_value
);

    wb_req_t         inst_req, data_req, ram_req;
    wb_resp_t        inst_resp, data_resp, ram_resp;
    inst_u           inst;
    logic [XLEN-1:0] pc, next_pc;
    logic            inst_valid, inst_taken;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .wb_req    (inst_req),
        .wb_resp   (inst_resp),
        .inst      (inst),
        .pc        (pc),
        .inst_valid(inst_valid),
        .inst_taken(inst_taken),
        .next_pc   (next_pc)
    );

    core_ctrl u_core (
        .clk(clk), .rst(rst),
        .inst      (inst),
        .pc        (pc),
        .inst_valid(inst_valid),
        .inst_taken(inst_taken),
        .next_pc   (next_pc),
        .wb_req    (data_req),
        .wb_resp   (data_resp),
        .halted    (halted),
        .trap      (trap),
        .trap_pc   (trap_pc),
        .exit_value(exit_value)
    );

    wb_arbiter u_arb (
        .clk(clk), .rst(rst),
        .m_host_req (host_req),
        .m_data_req (data_req),
        .m_inst_req (inst_req),
        .m_host_resp(host_resp),
        .m_data_resp(data_resp),
        .m_inst_resp(inst_resp),
        .s_req      (ram_req),
        .s_resp     (ram_resp)
    );

    wb_ram u_ram (
        .clk (clk),
        .rst (rst),
        .req (ram_req),
        .resp(ram_resp)
    );

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`default_nettype none

module cpu_tb
    import wb_pkg::*;
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_ALU  = 0;
    localparam int K_MEM  = 1;
    localparam int K_FLOW = 2;
    localparam int K_TRAP = 3;
    localparam int K_MIX  = 4;
    localparam int HOST_TIMEOUT = 200;
    localparam int RUN_TIMEOUT  = 50000;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic            clk = 1'b0;
    logic            rst;
    logic            run;
    wb_req_t         host_req;
    wb_resp_t        host_resp;
    logic            halted;
    logic            trap;
    logic [XLEN-1:0] trap_pc;
    logic [XLEN-1:0] exit_value;

    logic [WB_DATA_W-1:0] mmem [0:(1<<WB_ADDR_W)-1];  // mirror of the RAM
    logic [XLEN-1:0]      mreg [0:31];
    logic [31:0]          prog [0:255];
    int                   plen;
    logic [31:0]          rng_state = 32'd67;
    int                   err_value = 0;
    int                   err_timeout = 0;

    cpu_top UUT (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .host_req  (host_req),
        .host_resp (host_resp),
        .halted    (halted),
        .trap      (trap),
        .trap_pc   (trap_pc),
        .exit_value(exit_value)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r % n);
    endfunction

    function automatic logic [31:0] fill_value(input logic [9:0] a);
        return {a, ~a, a, 2'b01};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // picks one of the data registers x1..x7 and x10
    function automatic logic [4:0] pick_reg();
        int idx;
        idx = rand_below(8);
        return (idx == 7) ? 5'd10 : 5'(idx + 1);
    endfunction

    function automatic logic [4:0] pick_src();
        return (rand_below(8) == 0) ? 5'd0 : pick_reg();
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[plen] = w;
        plen++;
    endtask

    task automatic emit_alu();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = next_rand();
        rd  = pick_reg();
        rs1 = pick_src();
        rs2 = pick_src();
        case (rand_below(7))
            0: emit(enc_u(r[19:0], rd));
            1: emit(enc_i(r[11:0], rs1, 3'b000, rd, OP_IMM));
            2: emit(enc_r(7'h00, rs2, rs1, 3'b000, rd));
            3: emit(enc_r(7'h20, rs2, rs1, 3'b000, rd));
            4: emit(enc_r(7'h00, rs2, rs1, 3'b111, rd));
            5: emit(enc_r(7'h00, rs2, rs1, 3'b110, rd));
            default: emit(enc_r(7'h00, rs2, rs1, 3'b100, rd));
        endcase
    endtask

    task automatic emit_mem();
        logic [31:0] target;
        logic [31:0] base;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [11:0] off;
        target = 32'd2048 + 32'(4 * rand_below(256));  // byte address inside words 512..767
        off    = 12'(4 * rand_below(16) - 32);
        base   = target - {{20{off[11]}}, off};
        hi     = (base + 32'h800) >> 12;
        lo     = base - (hi << 12);
        emit(enc_u(hi[19:0], 5'd8));  // x8 holds the memory base
        emit(enc_i(lo[11:0], 5'd8, 3'b000, 5'd8, OP_IMM));
        if (rand_below(2) == 0) emit(enc_s(off, pick_reg(), 5'd8));
        else emit(enc_i(off, 5'd8, 3'b010, pick_reg(), OP_LOAD));
    endtask

    task automatic emit_branch();
        int         k;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        k   = 1 + rand_below(3);
        rs1 = pick_reg();
        rs2 = (rand_below(3) == 0) ? rs1 : pick_reg();  // same reg forces the outcome
        f3  = (rand_below(2) == 0) ? F3_BEQ : F3_BNE;
        emit(enc_b(13'((k + 1) * 4), rs2, rs1, f3));
        repeat (k) emit_alu();
    endtask

    task automatic emit_jal();
        int k;
        k = rand_below(4);
        emit(enc_j(21'((k + 1) * 4), 5'd9));
        repeat (k) emit_alu();
        emit(enc_r(7'h00, 5'd9, 5'd10, 3'b000, 5'd10));  // fold the link into x10
    endtask

    task automatic gen_program(input int kind);
        logic [31:0] r32;
        int          n;
        int          bad_at;
        int          choice;
        plen = 0;
        for (int r = 1; r <= 10; r++) begin
            r32 = next_rand();
            emit(enc_i(r32[11:0], 5'd0, 3'b000, 5'(r), OP_IMM));
        end
        n      = 30 + rand_below(20);
        bad_at = rand_below(n);
        for (int i = 0; i < n && plen < 220; i++) begin
            choice = rand_below(4);
            case (kind)
                K_ALU: emit_alu();
                K_MEM: begin
                    if (choice < 2) emit_mem();
                    else emit_alu();
                end
                K_FLOW: begin
                    case (choice)
                        0: emit_branch();
                        1: emit_jal();
                        default: emit_alu();
                    endcase
                end
                K_TRAP: begin
                    if (i == bad_at) begin
                        r32 = next_rand();
                        emit({r32[31:7], 7'b0001011});  // custom-0 opcode is outside the subset
                    end
                    emit_alu();
                end
                default: begin
                    case (choice)
                        0: emit_alu();
                        1: emit_mem();
                        2: emit_branch();
                        default: emit_jal();
                    endcase
                end
            endcase
        end
        emit(EBREAK);
    endtask

    // instruction-set interpreter over mmem and mreg
    task automatic model_run(output logic m_trap, output logic [31:0] m_trap_pc);
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] val;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr;
        logic        bad;
        logic        taken;
        logic        done;
        int          steps;
        pc        = 32'd0;
        m_trap    = 1'b0;
        m_trap_pc = 32'd0;
        done      = 1'b0;
        steps     = 0;
        mreg[0]   = '0;
        while (!done && steps < 10000) begin
            w     = mmem[pc[11:2]];
            rd    = w[11:7];
            f3    = w[14:12];
            f7    = w[31:25];
            a     = mreg[w[19:15]];
            b     = mreg[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            npc   = pc + 32'd4;
            wr    = 1'b0;
            bad   = 1'b0;
            taken = 1'b0;
            val   = '0;
            case (w[6:0])
                OP_LUI: begin
                    wr  = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                OP_IMM: begin
                    bad = (f3 != 3'b000);
                    wr  = 1'b1;
                    val = a + imm_i;
                end
                OP_REG: begin
                    wr = 1'b1;
                    case ({f7, f3})
                        {7'h00, 3'b000}: val = a + b;
                        {7'h20, 3'b000}: val = a - b;
                        {7'h00, 3'b111}: val = a & b;
                        {7'h00, 3'b110}: val = a | b;
                        {7'h00, 3'b100}: val = a ^ b;
                        default:         bad = 1'b1;
                    endcase
                end
                OP_LOAD: begin
                    bad = (f3 != 3'b010);
                    wr  = 1'b1;
                    ea  = a + imm_i;
                    val = mmem[ea[11:2]];
                end
                OP_STORE: begin
                    bad = (f3 != 3'b010);
                    ea  = a + imm_s;
                    if (!bad) mmem[ea[11:2]] = b;
                end
                OP_BRANCH: begin
                    case (f3)
                        3'b000:  taken = (a == b);  // beq
                        3'b001:  taken = (a != b);  // bne
                        default: bad = 1'b1;
                    endcase
                    if (taken) npc = pc + imm_b;
                end
                OP_JAL: begin
                    wr  = 1'b1;
                    val = pc + 32'd4;
                    npc = pc + imm_j;
                end
                OP_SYSTEM: begin
                    done = 1'b1;
                    bad  = (w != EBREAK);
                end
                default: bad = 1'b1;
            endcase
            if (bad) begin
                done      = 1'b1;
                m_trap    = 1'b1;
                m_trap_pc = pc;
            end else if (!done) begin
                if (wr && rd != 5'd0) mreg[rd] = val;
                pc = npc;
            end
            steps++;
        end
        if (!done) begin
            $display("The model ran past its step limit without halting.");
            err_timeout++;
        end
    endtask

    task automatic host_write(input logic [WB_ADDR_W-1:0] adr, input logic [3:0] sel,
                              input logic [31:0] data);
        int n;
        host_req.cyc   = 1'b1;
        host_req.stb   = 1'b1;
        host_req.we    = 1'b1;
        host_req.sel   = sel;
        host_req.adr   = adr;
        host_req.dat_w = data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_resp.ack && n < HOST_TIMEOUT);
        if (!host_resp.ack) begin
            $display("Host write to word %0d was never acknowledged.", adr);
            err_timeout++;
        end
        host_req = '0;
        @(negedge clk);  // one idle cycle lets the arbiter release
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) mmem[adr][i*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic host_read(input logic [WB_ADDR_W-1:0] adr, output wb_resp_t resp);
        int n;
        host_req     = '0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.sel = 4'hf;
        host_req.adr = adr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_resp.ack && n < HOST_TIMEOUT);
        resp = host_resp;
        if (!host_resp.ack) begin
            $display("Host read of word %0d was never acknowledged.", adr);
            err_timeout++;
        end
        host_req = '0;
        @(negedge clk);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("Error %s: got %h expected %h", name, got, want);
            err_value++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Error %s: got %h expected %h", name, got, want);
            err_value++;
        end
    endtask

    task automatic check_resp(input string name, input wb_resp_t got, input wb_resp_t want);
        if (got !== want) begin
            $display("Error %s: got ack=%h dat_r=%h expected ack=%h dat_r=%h",
                     name, got.ack, got.dat_r, want.ack, want.dat_r);
            err_value++;
        end
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < RUN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("The core did not halt within %0d cycles.", RUN_TIMEOUT);
            err_timeout++;
        end
    endtask

    task automatic reset_dut();
        rst      = 1'b1;
        run      = 1'b0;
        host_req = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_program(input int kind, input bit contend);
        logic                 m_trap;
        logic [31:0]          m_trap_pc;
        logic [WB_ADDR_W-1:0] adr;
        wb_resp_t             resp;
        wb_resp_t             want;
        int                   n;
        int                   w;
        reset_dut();
        gen_program(kind);
        for (int i = 0; i < plen; i++) host_write(WB_ADDR_W'(i), 4'hf, prog[i]);
        model_run(m_trap, m_trap_pc);
        run = 1'b1;
        n = 0;
        while (contend && !halted && n < 400) begin
            w   = rand_below(512);
            adr = WB_ADDR_W'((w < 256) ? 256 + w : 512 + w);  // outside program and data
            host_read(adr, resp);
            want.ack   = 1'b1;
            want.dat_r = mmem[adr];
            check_resp($sformatf("host_resp[%0d]", adr), resp, want);
            repeat (1 + rand_below(3)) @(negedge clk);
            n++;
        end
        wait_halted();
        run = 1'b0;
        check_flag("halted", halted, 1'b1);
        check_flag("trap", trap, m_trap);
        if (m_trap) check_word("trap_pc", trap_pc, m_trap_pc);
        check_word("exit_value", exit_value, mreg[10]);
        if (kind == K_MEM || kind == K_MIX) begin
            for (int a = 512; a < 768; a++) begin
                host_read(WB_ADDR_W'(a), resp);
                check_word($sformatf("mem[%0d]", a), resp.dat_r, mmem[a]);
            end
        end
    endtask

    initial begin
        logic [31:0]          d;
        logic [WB_ADDR_W-1:0] a;
        wb_resp_t             resp;
        wb_resp_t             want;
        reset_dut();
        for (int i = 0; i < (1 << WB_ADDR_W); i++) begin
            host_write(WB_ADDR_W'(i), 4'hf, fill_value(WB_ADDR_W'(i)));
        end
        // host port alone with random byte selects
        for (int i = 0; i < 300; i++) begin
            d = next_rand();
            host_write(d[9:0], d[13:10], next_rand());
        end
        for (int i = 0; i < 300; i++) begin
            d = next_rand();
            a = d[9:0];
            host_read(a, resp);
            want.ack   = 1'b1;
            want.dat_r = mmem[a];
            check_resp($sformatf("host_resp[%0d]", a), resp, want);
        end
        repeat (3) run_program(K_ALU, 1'b0);
        repeat (3) run_program(K_MEM, 1'b0);
        repeat (3) run_program(K_FLOW, 1'b0);
        repeat (3) run_program(K_TRAP, 1'b0);
        repeat (3) run_program(K_MIX, 1'b1);
        $display("Summary: %0d value mismatches, %0d timeouts", err_value, err_timeout);
        if (err_value + err_timeout == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #20_000_000;
        $display("The simulation ran past its overall time limit.");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/wb_pkg.sv
design/rv_isa_pkg.sv
design/regfile.sv
design/alu.sv
design/fetch_unit.sv
design/core_ctrl.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/cpu_top.sv
verif/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= cpu_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
